// File: rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

`define RV_XLEN        32
`define RV_REG_ADDR_W  5

`define RV_RESET_PC    32'h0000_0000
`define RV_NOP         32'h0000_0013     // ADDI x0, x0, 0

// Major opcodes, instr[6:0]
`define RV_OP_LUI      7'b0110111
`define RV_OP_AUIPC    7'b0010111
`define RV_OP_JAL      7'b1101111
`define RV_OP_JALR     7'b1100111
`define RV_OP_BRANCH   7'b1100011
`define RV_OP_LOAD     7'b0000011
`define RV_OP_STORE    7'b0100011
`define RV_OP_IMM      7'b0010011
`define RV_OP_REG      7'b0110011

`endif

// File: rv_pkg.sv
`include "rv_macros.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0]       word_t;
    typedef logic [`RV_REG_ADDR_W-1:0] reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
        ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
        ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        FWD_NONE = 2'b00,   // Register file value
        FWD_WB   = 2'b01,
        FWD_MEM  = 2'b10
    } fwd_sel_t;

    // ==============================
    // Stage payloads
    // ==============================

    typedef struct packed {
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    jump;
        logic    is_jalr;
        logic    src_a_pc;      // AUIPC
        logic    src_b_imm;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        word_t      pc;
        word_t      rs1_data;
        word_t      rs2_data;
        word_t      imm;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        logic [2:0] funct3;     // Branch condition
        ctrl_t      ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t    alu_result;   // Also the data address
        word_t    store_data;
        reg_idx_t rd;
        logic     reg_write;
        logic     mem_read;
        logic     mem_write;
    } ex_mem_t;

    typedef struct packed {
        word_t    wb_data;
        reg_idx_t rd;
        logic     reg_write;
    } mem_wb_t;

    typedef struct packed {
        word_t addr;
        word_t wdata;
        logic  we;
    } dmem_req_t;

endpackage

// File: pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     hold,
    input  logic     bubble,
    input  payload_t d,
    output payload_t q
);

    // All-zero payload is a NOP, control bits cleared
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            q <= '0;
        end else if (bubble) begin  // Bubble beats hold
            q <= '0;
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

// File: regfile.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module regfile
    import rv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  mem_wb_t  wr
);

    localparam int NUM_REGS = 1 << `RV_REG_ADDR_W;

    word_t regs [NUM_REGS];
    logic  wr_en;

    assign wr_en = wr.reg_write && (wr.rd != '0);   // x0 never written

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.rd] <= wr.wb_data;
        end
    end

    // Write-through covers the WB to ID gap
    assign rs1_data = (rs1 == '0)                  ? '0         :
                      (wr_en && (wr.rd == rs1))    ? wr.wb_data :
                                                     regs[rs1];
    assign rs2_data = (rs2 == '0)                  ? '0         :
                      (wr_en && (wr.rd == rs2))    ? wr.wb_data :
                                                     regs[rs2];

endmodule

// File: decode_unit.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module decode_unit
    import rv_pkg::*;
(
    input  if_id_t   if_id,
    output reg_idx_t rs1,
    output reg_idx_t rs2,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output id_ex_t   id_ex
);

    word_t      instr;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;            // funct7 bit 5
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm;
    ctrl_t      ctrl;

    // ALU operation from funct3, sub_sra picks SUB or SRA
    function automatic alu_op_t funct_to_alu(logic [2:0] f3, logic sub_sra);
        case (f3)
            3'b000:  return sub_sra ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return sub_sra ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign instr  = if_id.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt    = instr[30];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // Immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        ctrl = '0;                  // Unknown opcode stays a NOP
        imm  = imm_i;
        case (opcode)
            `RV_OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_b_imm = 1'b1;
                ctrl.alu_op    = ALU_PASS_B;
                imm            = imm_u;
            end
            `RV_OP_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_a_pc  = 1'b1;
                ctrl.src_b_imm = 1'b1;
                imm            = imm_u;
            end
            `RV_OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                imm            = imm_j;
            end
            `RV_OP_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.is_jalr   = 1'b1;
            end
            `RV_OP_BRANCH: begin
                ctrl.branch = 1'b1;
                imm         = imm_b;
            end
            `RV_OP_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.src_b_imm = 1'b1;
            end
            `RV_OP_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.src_b_imm = 1'b1;
                imm            = imm_s;
            end
            `RV_OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.src_b_imm = 1'b1;
                // Bit 30 is immediate data except for SRAI
                ctrl.alu_op    = funct_to_alu(funct3, (funct3 == 3'b101) && alt);
            end
            `RV_OP_REG: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = funct_to_alu(funct3, alt);
            end
            default: ;
        endcase
    end

    always_comb begin
        id_ex.pc       = if_id.pc;
        id_ex.rs1_data = rs1_data;
        id_ex.rs2_data = rs2_data;
        id_ex.imm      = imm;
        id_ex.rs1      = rs1;
        id_ex.rs2      = rs2;
        id_ex.rd       = instr[11:7];
        id_ex.funct3   = funct3;
        id_ex.ctrl     = ctrl;
    end

endmodule

// File: hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
    import rv_pkg::*;
(
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  id_ex_t   id_ex,
    input  ex_mem_t  ex_mem,
    input  mem_wb_t  mem_wb,
    output logic     load_use_stall,
    output fwd_sel_t fwd_a,
    output fwd_sel_t fwd_b
);

    // MEM first, then WB; x0 never forwards
    function automatic fwd_sel_t pick_fwd(reg_idx_t src, ex_mem_t em, mem_wb_t mw);
        if (src == '0) return FWD_NONE;
        if (em.reg_write && (em.rd == src)) return FWD_MEM;
        if (mw.reg_write && (mw.rd == src)) return FWD_WB;
        return FWD_NONE;
    endfunction

    // ==============================
    // Load-use, decode vs EX
    // ==============================
    assign load_use_stall = id_ex.ctrl.mem_read && (id_ex.rd != '0) &&
                            ((id_ex.rd == rs1) || (id_ex.rd == rs2));

    // Sources of the instruction now in EX
    assign fwd_a = pick_fwd(id_ex.rs1, ex_mem, mem_wb);
    assign fwd_b = pick_fwd(id_ex.rs2, ex_mem, mem_wb);

endmodule

// File: execute_unit.sv
`timescale 1ns/1ps

module execute_unit
    import rv_pkg::*;
(
    input  id_ex_t   id_ex,
    input  fwd_sel_t fwd_a,
    input  fwd_sel_t fwd_b,
    input  word_t    mem_fwd,
    input  word_t    wb_fwd,
    output ex_mem_t  ex_mem,
    output logic     redirect,
    output word_t    redirect_target
);

    word_t op_a;                // rs1 after forwarding
    word_t op_b;                // rs2 after forwarding
    word_t alu_a;
    word_t alu_b;
    word_t alu_out;
    word_t link_addr;
    logic  cond_met;

    // ==============================
    // Operand forwarding
    // ==============================
    assign op_a = (fwd_a == FWD_MEM) ? mem_fwd :
                  (fwd_a == FWD_WB)  ? wb_fwd  :
                                       id_ex.rs1_data;
    assign op_b = (fwd_b == FWD_MEM) ? mem_fwd :
                  (fwd_b == FWD_WB)  ? wb_fwd  :
                                       id_ex.rs2_data;

    assign alu_a = id_ex.ctrl.src_a_pc  ? id_ex.pc  : op_a;
    assign alu_b = id_ex.ctrl.src_b_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_ADD:    alu_out = alu_a + alu_b;
            ALU_SUB:    alu_out = alu_a - alu_b;
            ALU_SLL:    alu_out = alu_a << alu_b[4:0];
            ALU_SLT:    alu_out = word_t'($signed(alu_a) < $signed(alu_b));
            ALU_SLTU:   alu_out = word_t'(alu_a < alu_b);
            ALU_XOR:    alu_out = alu_a ^ alu_b;
            ALU_SRL:    alu_out = alu_a >> alu_b[4:0];
            ALU_SRA:    alu_out = word_t'($signed(alu_a) >>> alu_b[4:0]);
            ALU_OR:     alu_out = alu_a | alu_b;
            ALU_AND:    alu_out = alu_a & alu_b;
            ALU_PASS_B: alu_out = alu_b;            // LUI
            default:    alu_out = alu_a + alu_b;
        endcase
    end

    // Branch condition on forwarded registers
    always_comb begin
        case (id_ex.funct3)
            3'b000:  cond_met = (op_a == op_b);                     // BEQ
            3'b001:  cond_met = (op_a != op_b);                     // BNE
            3'b100:  cond_met = ($signed(op_a) < $signed(op_b));    // BLT
            3'b101:  cond_met = ($signed(op_a) >= $signed(op_b));   // BGE
            3'b110:  cond_met = (op_a < op_b);
            3'b111:  cond_met = (op_a >= op_b);
            default: cond_met = 1'b0;
        endcase
    end

    // ==============================
    // Redirect, not-taken predicted
    // ==============================
    assign link_addr       = id_ex.pc + 32'd4;
    assign redirect        = (id_ex.ctrl.branch && cond_met) || id_ex.ctrl.jump;
    assign redirect_target = id_ex.ctrl.is_jalr ? ((op_a + id_ex.imm) & ~word_t'(1))
                                                : (id_ex.pc + id_ex.imm);

    always_comb begin
        ex_mem.alu_result = id_ex.ctrl.jump ? link_addr : alu_out;
        ex_mem.store_data = op_b;
        ex_mem.rd         = id_ex.rd;
        ex_mem.reg_write  = id_ex.ctrl.reg_write;
        ex_mem.mem_read   = id_ex.ctrl.mem_read;
        ex_mem.mem_write  = id_ex.ctrl.mem_write;
    end

endmodule

// File: riscv_core.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module riscv_core
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    output word_t     pc,
    input  word_t     instruction,
    input  logic      instruction_grant,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata
);

    if_id_t   if_id_d;
    if_id_t   if_id_q;
    id_ex_t   id_ex_d;
    id_ex_t   id_ex_q;
    ex_mem_t  ex_mem_d;
    ex_mem_t  ex_mem_q;
    mem_wb_t  mem_wb_d;
    mem_wb_t  mem_wb_q;

    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;
    fwd_sel_t fwd_a;
    fwd_sel_t fwd_b;
    logic     load_use_stall;
    logic     redirect;
    word_t    redirect_target;
    logic     fetch_stall;      // Freezes everything
    logic     if_id_hold;
    logic     if_id_bubble;
    logic     id_ex_bubble;
    word_t    pc_next;

    // ==============================
    // Stall and flush control
    // ==============================
    assign fetch_stall  = !instruction_grant;
    assign if_id_hold   = fetch_stall || load_use_stall;
    assign if_id_bubble = !fetch_stall && redirect;
    assign id_ex_bubble = !fetch_stall && (redirect || load_use_stall);

    always_comb begin
        if (fetch_stall || (!redirect && load_use_stall)) begin
            pc_next = pc;
        end else if (redirect) begin
            pc_next = redirect_target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // ==============================
    // IF / ID
    // ==============================
    assign if_id_d = '{pc: pc, instr: instruction};

    pipe_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk(clk), .rst_n(rst_n), .hold(if_id_hold), .bubble(if_id_bubble),
        .d(if_id_d), .q(if_id_q)
    );

    decode_unit decode_unit_inst (
        .if_id(if_id_q), .rs1(rs1_idx), .rs2(rs2_idx),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .id_ex(id_ex_d)
    );

    regfile regfile_inst (
        .clk(clk), .rst_n(rst_n), .rs1(rs1_idx), .rs2(rs2_idx),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .wr(mem_wb_q)
    );

    hazard_unit hazard_unit_inst (
        .rs1(rs1_idx), .rs2(rs2_idx), .id_ex(id_ex_q), .ex_mem(ex_mem_q),
        .mem_wb(mem_wb_q), .load_use_stall(load_use_stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
    );

    // ==============================
    // EX
    // ==============================
    pipe_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk(clk), .rst_n(rst_n), .hold(fetch_stall), .bubble(id_ex_bubble),
        .d(id_ex_d), .q(id_ex_q)
    );

    execute_unit execute_unit_inst (
        .id_ex(id_ex_q), .fwd_a(fwd_a), .fwd_b(fwd_b),
        .mem_fwd(ex_mem_q.alu_result), .wb_fwd(mem_wb_q.wb_data),
        .ex_mem(ex_mem_d), .redirect(redirect), .redirect_target(redirect_target)
    );

    // ==============================
    // MEM and WB
    // ==============================
    pipe_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
        .clk(clk), .rst_n(rst_n), .hold(fetch_stall), .bubble(1'b0),
        .d(ex_mem_d), .q(ex_mem_q)
    );

    // Strobe masked while frozen so a held store writes once
    assign dmem_req = '{addr:  ex_mem_q.alu_result,
                        wdata: ex_mem_q.store_data,
                        we:    ex_mem_q.mem_write && !fetch_stall};

    assign mem_wb_d = '{wb_data:   ex_mem_q.mem_read ? dmem_rdata : ex_mem_q.alu_result,
                        rd:        ex_mem_q.rd,
                        reg_write: ex_mem_q.reg_write};

    pipe_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
        .clk(clk), .rst_n(rst_n), .hold(fetch_stall), .bubble(1'b0),
        .d(mem_wb_d), .q(mem_wb_q)
    );

endmodule

// File: riscv_core_props.sv
`timescale 1ns/1ps

module riscv_core_props
    import rv_pkg::*;
(
    input logic      clk,
    input logic      rst_n,
    input word_t     pc,
    input dmem_req_t dmem_req
);

    pc_aligned: assert property (@(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00)
        else $error("pc not word-aligned: %h", pc);

    // No store while in reset or just out of it
    we_low_in_reset: assert property (@(posedge clk) !rst_n |-> !dmem_req.we)
        else $error("dmem write during reset");

    we_low_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !dmem_req.we)
        else $error("dmem write on first cycle after reset");

    store_aligned: assert property (@(posedge clk) disable iff (!rst_n)
                                    dmem_req.we |-> dmem_req.addr[1:0] == 2'b00)
        else $error("misaligned store address %h", dmem_req.addr);

endmodule

bind riscv_core riscv_core_props riscv_core_props_inst (
    .clk(clk), .rst_n(rst_n), .pc(pc), .dmem_req(dmem_req)
);

// File: tb_riscv_core.sv
`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_riscv_core
    import rv_pkg::*;
();

    localparam int PROG_WORDS = 21 + 9 + 27 + 12 + 21 + 7;    // All six programs
    localparam int CYCLE_LIMIT = 4 * PROG_WORDS + 200;

    logic      clk;
    logic      rst_n;
    word_t     pc;
    word_t     instruction;
    logic      instruction_grant;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;

    word_t       prog [1024];
    word_t       dmem [1024];
    int          store_count [1024];
    int          prog_len;
    bit          done;
    int          cycles;
    int          test_errors;
    int          total_errors;
    int          tests_run;
    logic [15:0] lfsr = 16'd41;

    riscv_core riscv_core_inst (
        .clk(clk), .rst_n(rst_n), .pc(pc), .instruction(instruction),
        .instruction_grant(instruction_grant), .dmem_req(dmem_req), .dmem_rdata(dmem_rdata)
    );

    // Combinational memory models
    assign instruction = prog[pc[11:2]];
    assign dmem_rdata  = dmem[dmem_req.addr[11:2]];

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n && dmem_req.we) begin
            dmem[dmem_req.addr[11:2]] <= dmem_req.wdata;
            store_count[dmem_req.addr[11:2]] = store_count[dmem_req.addr[11:2]] + 1;
            if (dmem_req.addr == 32'h0000_0FFC) done = 1'b1;  // End of program
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: program did not reach its done store in %0d cycles", cycles);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ==============================
    // Instruction encoding
    // ==============================
    function automatic word_t enc_i(int imm, int rs1, int f3, int rd, logic [6:0] op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `RV_OP_REG};
    endfunction

    function automatic word_t enc_s(int imm, int rs2, int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], `RV_OP_STORE};
    endfunction

    function automatic word_t enc_b(int imm, int rs2, int rs1, int f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                `RV_OP_BRANCH};
    endfunction

    function automatic word_t enc_u(int upper, int rd, logic [6:0] op);
        return {upper[19:0], rd[4:0], op};
    endfunction

    function automatic word_t enc_j(int imm, int rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `RV_OP_JAL};
    endfunction

    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // Taps 16,14,13,11
    endfunction

    function automatic word_t fill_word(int i);
        return {16'hC0DE, 6'd0, i[9:0]};
    endfunction

    task automatic emit(word_t w);
        prog[prog_len] = w;
        prog_len = prog_len + 1;
    endtask

    task automatic new_program();
        prog_len = 0;
        for (int i = 0; i < 1024; i++) begin
            prog[i] = `RV_NOP;
            dmem[i] <= fill_word(i);
        end
    endtask

    task automatic emit_done();
        emit(enc_u(1, 31, `RV_OP_LUI));             // x31 = 0x1000
        emit(enc_s(-4, 0, 31));                     // Store to 0xFFC
    endtask

    task automatic run_program(input bit random_grant);
        rst_n = 1'b0;
        instruction_grant = 1'b1;
        done = 1'b0;
        for (int i = 0; i < 1024; i++) store_count[i] = 0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        while (!done) begin
            @(posedge clk);
            #1;
            if (random_grant) begin
                lfsr = lfsr_step(lfsr);
                instruction_grant = lfsr[0];
            end else begin
                instruction_grant = 1'b1;
            end
        end
        instruction_grant = 1'b1;
    endtask

    task automatic check_word(int idx, word_t exp);
        if (dmem[idx] !== exp) begin
            $display("FAILED dmem[%0d]: got %h, expected %h", idx, dmem[idx], exp);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic end_test(string name);
        $display("%s: %s (%0d errors)", name, (test_errors == 0) ? "ok" : "bad", test_errors);
        total_errors = total_errors + test_errors;
        tests_run = tests_run + 1;
        test_errors = 0;
    endtask

    // ==============================
    // Directed tests
    // ==============================
    task automatic load_alu_program();
        new_program();
        emit(enc_i(5, 0, 0, 1, `RV_OP_IMM));        // x1 = 5
        emit(enc_i(7, 1, 0, 2, `RV_OP_IMM));        // x2 = x1 + 7
        emit(enc_r(0, 2, 1, 0, 3));                 // add
        emit(enc_r(32, 2, 1, 0, 4));                // sub
        emit(enc_r(0, 4, 3, 4, 5));                 // xor
        emit(enc_r(0, 1, 3, 1, 6));                 // sll
        emit(enc_r(32, 1, 4, 5, 7));                // sra
        emit(enc_r(0, 1, 4, 2, 8));                 // slt
        emit(enc_u(32'h12345, 9, `RV_OP_LUI));
        emit(enc_u(1, 10, `RV_OP_AUIPC));           // At pc 36
        for (int r = 2; r <= 10; r++) emit(enc_s((r - 2) * 4, r, 0));
        emit_done();
    endtask

    task automatic check_alu_results();
        word_t x [11];
        x[1]  = 32'd5;
        x[2]  = x[1] + 32'd7;
        x[3]  = x[1] + x[2];
        x[4]  = x[1] - x[2];
        x[5]  = x[3] ^ x[4];
        x[6]  = x[3] << x[1][4:0];
        x[7]  = x[4] >> x[1][4:0];
        if (x[4][31]) x[7] = x[7] | ~(32'hFFFF_FFFF >> x[1][4:0]);    // Sign fill
        x[8]  = ($signed(x[4]) < $signed(x[1])) ? 32'd1 : 32'd0;
        x[9]  = 32'h1234_5000;
        x[10] = 32'd36 + 32'h0000_1000;
        for (int r = 2; r <= 10; r++) check_word(r - 2, x[r]);
    endtask

    task automatic test_alu();
        load_alu_program();
        run_program(1'b0);
        check_alu_results();
        end_test("alu_forwarding");
    endtask

    task automatic test_load_use();
        new_program();
        emit(enc_i(100, 0, 0, 1, `RV_OP_IMM));
        emit(enc_s(16, 1, 0));
        emit(enc_i(16, 0, 2, 2, `RV_OP_LOAD));
        emit(enc_r(0, 1, 2, 0, 3));                 // Uses the load at once
        emit(enc_s(20, 3, 0));
        emit(enc_i(20, 0, 2, 4, `RV_OP_LOAD));
        emit(enc_s(24, 4, 0));
        emit_done();
        run_program(1'b0);
        check_word(4, 32'd100);
        check_word(5, 32'd200);
        check_word(6, 32'd200);
        end_test("load_use");
    endtask

    task automatic test_branches();
        word_t a;
        word_t b;
        word_t acc;
        new_program();
        emit(enc_i(3, 0, 0, 1, `RV_OP_IMM));
        emit(enc_i(-2, 0, 0, 2, `RV_OP_IMM));
        emit(enc_i(0, 0, 0, 5, `RV_OP_IMM));
        emit(enc_b(12, 1, 1, 0));                   // beq taken
        emit(enc_s(32, 1, 0));
        emit(enc_i(100, 5, 0, 5, `RV_OP_IMM));
        emit(enc_i(1, 5, 0, 5, `RV_OP_IMM));
        emit(enc_b(8, 2, 1, 0));                    // beq not taken
        emit(enc_i(2, 5, 0, 5, `RV_OP_IMM));
        emit(enc_b(12, 2, 1, 1));                   // bne taken
        emit(enc_s(36, 1, 0));
        emit(enc_i(100, 5, 0, 5, `RV_OP_IMM));
        emit(enc_b(12, 1, 2, 4));                   // blt taken
        emit(enc_s(40, 1, 0));
        emit(enc_i(100, 5, 0, 5, `RV_OP_IMM));
        emit(enc_b(8, 2, 1, 7));                    // bgeu not taken
        emit(enc_i(4, 5, 0, 5, `RV_OP_IMM));
        emit(enc_b(12, 1, 2, 7));                   // bgeu taken
        emit(enc_s(44, 1, 0));
        emit(enc_i(100, 5, 0, 5, `RV_OP_IMM));
        emit(enc_b(8, 1, 1, 1));                    // bne not taken
        emit(enc_i(8, 5, 0, 5, `RV_OP_IMM));
        emit(enc_b(8, 2, 1, 4));                    // blt not taken
        emit(enc_i(16, 5, 0, 5, `RV_OP_IMM));
        emit(enc_s(48, 5, 0));
        emit_done();
        run_program(1'b0);
        a = 32'd3;
        b = 32'hFFFF_FFFE;
        acc = 32'd0;
        // Each add after a branch counts only when that branch falls through
        if (a != a) acc = acc + 32'd100;
        acc = acc + 32'd1;
        if (a != b) acc = acc + 32'd2;
        if (a == b) acc = acc + 32'd100;
        if (!($signed(b) < $signed(a))) acc = acc + 32'd100;
        if (!(a >= b)) acc = acc + 32'd4;
        if (!(b >= a)) acc = acc + 32'd100;
        if (a == a) acc = acc + 32'd8;
        if (!($signed(a) < $signed(b))) acc = acc + 32'd16;
        check_word(12, acc);
        for (int i = 8; i <= 11; i++) check_word(i, fill_word(i));  // Flushed stores
        end_test("branches");
    endtask

    task automatic test_jumps();
        new_program();
        emit(enc_j(12, 1));                         // jal to word 3
        emit(enc_s(52, 0, 0));
        emit(enc_i(99, 0, 0, 6, `RV_OP_IMM));
        emit(enc_i(29, 0, 0, 2, `RV_OP_IMM));       // Odd target
        emit(enc_i(0, 2, 0, 3, `RV_OP_JALR));
        emit(enc_s(56, 0, 0));
        emit(enc_i(99, 0, 0, 6, `RV_OP_IMM));
        emit(enc_s(60, 1, 0));
        emit(enc_s(64, 3, 0));
        emit(enc_s(68, 6, 0));
        emit_done();
        run_program(1'b0);
        check_word(15, 32'd0 + 32'd4);
        check_word(16, 32'd16 + 32'd4);
        check_word(17, 32'd0);
        check_word(13, fill_word(13));
        check_word(14, fill_word(14));
        end_test("jumps");
    endtask

    task automatic test_fetch_stall();
        int exp;
        load_alu_program();
        run_program(1'b1);
        check_alu_results();
        for (int i = 0; i < 1024; i++) begin
            exp = (i <= 8 || i == 1023) ? 1 : 0;
            if (store_count[i] != exp) begin
                $display("FAILED store_count[%0d]: got %h, expected %h", i,
                         store_count[i], exp);
                test_errors = test_errors + 1;
            end
        end
        end_test("fetch_stall");
    endtask

    task automatic test_x0();
        new_program();
        emit(enc_i(55, 0, 0, 0, `RV_OP_IMM));
        emit(enc_u(32'hABCDE, 0, `RV_OP_LUI));
        emit(enc_s(72, 0, 0));
        emit(enc_i(9, 0, 0, 1, `RV_OP_IMM));        // x0 must not forward
        emit(enc_s(76, 1, 0));
        emit_done();
        run_program(1'b0);
        check_word(18, 32'd0);
        check_word(19, 32'd9);
        end_test("register_x0");
    endtask

    initial begin
        rst_n = 1'b0;
        instruction_grant = 1'b1;
        cycles = 0;
        test_errors = 0;
        total_errors = 0;
        tests_run = 0;
        test_alu();
        test_load_use();
        test_branches();
        test_jumps();
        test_fetch_stall();
        test_x0();
        $display("Tests run %0d, errors %0d", tests_run, total_errors);
        if (total_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: compile.f
+incdir+.
rv_pkg.sv
pipe_reg.sv
regfile.sv
decode_unit.sv
hazard_unit.sv
execute_unit.sv
riscv_core.sv
riscv_core_props.sv
tb_riscv_core.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check sim.log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert --top-module tb_riscv_core -f compile.f
	./obj_dir/Vtb_riscv_core | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
